/* drum_patch.f */
+incdir+tests
rtl/drum_pkg.sv
rtl/node_update.sv
rtl/state_memory.sv
rtl/mem_arbiter.sv
rtl/patch_sweeper.sv
rtl/host_port.sv
rtl/drum_patch.sv
tests/drum_patch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the drum patch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f drum_patch.f --top-module drum_patch_tb \
	-Mdir obj_dir -o drum_patch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/drum_patch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

/* tests/drum_patch_tb_tasks.svh */
	logic [31:0] lcg_state = 32'h2cab;
	int          model_prev [node_count];
	int          model_cur  [node_count];

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// uniform in -amp .. amp
	function automatic sample_t random_sample(input int amp);
		int span;
		span = 2 * amp + 1;
		return sample_t'(int'((next_random() >> 8) % span) - amp);
	endfunction

	function automatic boundary_t make_edges(input sample_t right_edge, input sample_t left_edge,
		input sample_t up_edge, input sample_t down_edge);
		boundary_t b;
		b.right = right_edge;
		b.left  = left_edge;
		b.up    = up_edge;
		b.down  = down_edge;
		return b;
	endfunction

	function automatic int saturate(input longint value);
		if (value > 64'sd131071)
			return 131071;
		else if (value < -64'sd131072)
			return -131072;
		else
			return int'(value);
	endfunction

	// one time step of the whole patch, edges stand in for missing neighbours
	task automatic model_step();
		int     predicted [node_count];
		int     row;
		int     col;
		longint nbsum;
		longint prod;
		for (int n = 0; n < node_count; n++) begin
			row   = n / patch_dim;
			col   = n % patch_dim;
			nbsum = (col == patch_dim - 1) ? longint'(edges.right) : longint'(model_cur[n + 1]);
			nbsum += (col == 0) ? longint'(edges.left) : longint'(model_cur[n - 1]);
			nbsum += (row == 0) ? longint'(edges.up) : longint'(model_cur[n - patch_dim]);
			nbsum += (row == patch_dim - 1) ? longint'(edges.down)
				: longint'(model_cur[n + patch_dim]);
			prod = (nbsum - (longint'(model_cur[n]) <<< 2)) * longint'(rho);
			predicted[n] = saturate((prod >>> frac_bits) + (longint'(model_cur[n]) <<< 1)
				- longint'(model_prev[n]));
		end
		for (int n = 0; n < node_count; n++) begin
			model_prev[n] = model_cur[n];
			model_cur[n]  = predicted[n];
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail time %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic host_load(input node_addr_t addr, input sample_t value);
		host_addr = addr;
		host_data = value;
		load      = 1'b1;
		@(negedge clock);
		load = 1'b0;
		check_bit("host_busy", 1'b1, host_busy);
		while (host_busy) @(negedge clock);
	endtask

	task automatic host_read(input node_addr_t addr, output sample_t value);
		host_addr = addr;
		read      = 1'b1;
		@(negedge clock);
		read = 1'b0;
		check_bit("host_busy", 1'b1, host_busy);
		while (!read_valid) @(negedge clock);
		value = read_data;
		@(negedge clock);	// port back to idle
	endtask

	task automatic check_readback(input logic interior_zero);
		sample_t got;
		int      row;
		int      col;
		for (int n = 0; n < node_count; n++) begin
			host_read(node_addr_t'(n), got);
			row = n / patch_dim;
			col = n % patch_dim;
			if (int'(got) != model_cur[n]) begin
				value_errors++;
				$display("Fail time %0t: read_data node %0d expected %0d got %0d", $time,
					n, model_cur[n], got);
			end
			if (interior_zero && row > 0 && row < patch_dim - 1 && col > 0
				&& col < patch_dim - 1 && got != '0) begin
				value_errors++;
				$display("Fail time %0t: read_data interior node %0d expected 0 got %0d",
					$time, n, got);
			end
		end
	endtask

	task automatic run_sweep(input int reads);
		int         target;
		sample_t    got;
		node_addr_t addr;
		target = done_count + 1;
		start  = 1'b1;
		@(negedge clock);
		start = 1'b0;
		check_bit("busy", 1'b1, busy);
		for (int k = 0; k < reads; k++) begin
			addr = node_addr_t'((k * 5) % node_count);
			if (!busy) begin
				other_errors++;
				$display("sweep finished before host read %0d could be issued", k);
			end
			host_read(addr, got);	// level_cur is untouched until the rotate
			if (int'(got) != model_cur[addr]) begin
				value_errors++;
				$display("Fail time %0t: read_data node %0d expected %0d got %0d", $time,
					addr, model_cur[addr], got);
			end
		end
		while (done_count < target) @(negedge clock);
		check_bit("busy", 1'b0, busy);
	endtask

/* tests/drum_patch_tb.sv */
`timescale 1ns/1ps

module drum_patch_tb import drum_pkg::*; ();

	localparam int frac_bits  = 17;
	localparam int case_count = 5;

	typedef struct packed {
		sample_t     rho;
		logic        rand_rho;	// draw rho from the lcg
		boundary_t   edges;
		logic [15:0] amp;	// hit amplitude, zero for a flat field
		logic [3:0]  sweeps;
		logic        host_reads;	// host reads while the sweep runs
	} test_case_t;

	logic       clock;
	logic       reset;
	logic       start;
	sample_t    rho;
	boundary_t  edges;
	logic       load;
	logic       read;
	node_addr_t host_addr;
	sample_t    host_data;
	logic       busy;
	logic       done;
	logic       host_busy;
	sample_t    read_data;
	logic       read_valid;

	test_case_t cases [case_count];
	int         value_errors;
	int         other_errors;
	int         done_count;

	drum_patch #(.frac_bits(frac_bits)) DUT (
		.clock, .reset, .start, .rho, .edges, .load, .read, .host_addr, .host_data,
		.busy, .done, .host_busy, .read_data, .read_valid
	);

	`include "drum_patch_tb_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		if (!reset)
			done_count <= 0;
		else if (done)
			done_count <= done_count + 1;
	end

	task automatic fill_table();
		cases[0] = '{rho: 18'sd32768, rand_rho: 1'b0, edges: '0,
			amp: 16'd0, sweeps: 4'd3, host_reads: 1'b0};	// flat and silent
		cases[1] = '{rho: 18'sd0, rand_rho: 1'b1, edges: '0,
			amp: 16'd1024, sweeps: 4'd4, host_reads: 1'b0};
		cases[2] = '{rho: 18'sd40000, rand_rho: 1'b0,
			edges: make_edges(18'sd1000, -18'sd2000, 18'sd3000, -18'sd500),
			amp: 16'd0, sweeps: 4'd1, host_reads: 1'b0};	// edges only
		cases[3] = '{rho: 18'sd131071, rand_rho: 1'b0,
			edges: make_edges(18'sd20000, 18'sd20000, -18'sd20000, -18'sd20000),
			amp: 16'd4000, sweeps: 4'd4, host_reads: 1'b0};	// unstable, saturates
		cases[4] = '{rho: 18'sd24576, rand_rho: 1'b0,
			edges: make_edges(18'sd300, -18'sd300, 18'sd0, 18'sd150),
			amp: 16'd2000, sweeps: 4'd2, host_reads: 1'b1};
	endtask

	task automatic run_case(input test_case_t tc);
		int      first_done;
		sample_t value;
		rho   = tc.rand_rho ? sample_t'(next_random() >> 16) : tc.rho;	// below 0.5
		edges = tc.edges;
		for (int n = 0; n < node_count; n++) begin
			value = (tc.amp == 16'd0) ? '0 : random_sample(int'(tc.amp));
			model_cur[n]  = int'(value);
			model_prev[n] = 0;
			host_load(node_addr_t'(n), value);
		end
		check_readback(1'b0);
		first_done = done_count;
		for (int s = 0; s < int'(tc.sweeps); s++) begin
			run_sweep(tc.host_reads ? 6 : 0);
			model_step();
			check_readback(s == 0 && tc.amp == 16'd0);
		end
		if (done_count - first_done != int'(tc.sweeps)) begin
			value_errors++;
			$display("Fail time %0t: done pulses expected %0d got %0d", $time,
				tc.sweeps, done_count - first_done);
		end
	endtask

	initial begin
		int limit;
		limit = 3000;	// loads, readbacks and reset
		@(posedge clock);
		for (int c = 0; c < case_count; c++)
			limit += int'(cases[c].sweeps) * node_count * 20;
		repeat (limit) @(posedge clock);
		$display("timeout: run did not finish within %0d clock cycles", limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		value_errors = 0;
		other_errors = 0;
		fill_table();
		reset     = 1'b0;
		start     = 1'b0;
		load      = 1'b0;
		read      = 1'b0;
		rho       = '0;
		edges     = '0;
		host_addr = '0;
		host_data = '0;
		repeat (5) @(negedge clock);
		reset = 1'b1;
		@(negedge clock);
		check_bit("busy", 1'b0, busy);
		check_bit("done", 1'b0, done);
		check_bit("host_busy", 1'b0, host_busy);
		check_bit("read_valid", 1'b0, read_valid);
		for (int c = 0; c < case_count; c++)
			run_case(cases[c]);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* rtl/drum_patch.sv */
`timescale 1ns/1ps

module drum_patch import drum_pkg::*; #(
	parameter int frac_bits = 17
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  sample_t    rho,
	input  boundary_t  edges,
	input  logic       load,
	input  logic       read,
	input  node_addr_t host_addr,
	input  sample_t    host_data,
	output logic       busy,
	output logic       done,
	output logic       host_busy,
	output sample_t    read_data,
	output logic       read_valid
);

	mem_req_t    host_req;
	mem_req_t    sweep_req;
	mem_req_t    mem_req;
	logic        host_grant;
	logic        sweep_grant;
	sample_t     rdata;	// shared read bus
	logic        rotate;
	logic        launch;
	neighbours_t nb;
	sample_t     u_next;
	logic        u_next_valid;

	host_port u_host (
		.clock, .reset, .load, .read, .host_addr, .host_data,
		.mem_req(host_req), .grant(host_grant), .rdata,
		.host_busy, .read_data, .read_valid
	);

	patch_sweeper u_sweep (
		.clock, .reset, .start, .edges,
		.mem_req(sweep_req), .grant(sweep_grant), .rdata,
		.launch, .nb, .u_next, .u_next_valid,
		.rotate, .busy, .done
	);

	mem_arbiter u_arb (
		.host_req, .sweep_req, .host_grant, .sweep_grant, .mem_req
	);

	state_memory u_mem (
		.clock, .reset, .req(mem_req), .rotate, .rdata
	);

	node_update #(
		.frac_bits(frac_bits)
	) u_update (
		.clock, .reset, .launch, .rho, .nb, .u_next, .u_next_valid
	);

endmodule

/* rtl/host_port.sv */
`timescale 1ns/1ps

module host_port import drum_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       load,
	input  logic       read,
	input  node_addr_t host_addr,
	input  sample_t    host_data,
	output mem_req_t   mem_req,
	input  logic       grant,
	input  sample_t    rdata,
	output logic       host_busy,
	output sample_t    read_data,
	output logic       read_valid
);

	host_state_t state;
	node_addr_t  addr_q;
	sample_t     data_q;
	sample_t     read_hold;	// last returned value

	always_comb begin
		mem_req      = '0;
		mem_req.addr = addr_q;
		case (state)
			h_wr_cur: begin
				mem_req.req   = 1'b1;
				mem_req.we    = 1'b1;
				mem_req.level = level_cur;
				mem_req.wdata = data_q;
			end
			h_wr_prev: begin
				mem_req.req   = 1'b1;
				mem_req.we    = 1'b1;
				mem_req.level = level_prev;	// wdata stays zero
			end
			h_rd: begin
				mem_req.req   = 1'b1;
				mem_req.level = level_cur;
			end
			default: ;
		endcase
	end

	assign host_busy  = (state != h_idle);
	assign read_valid = (state == h_rd_wait);
	assign read_data  = read_valid ? rdata : read_hold;

	always_ff @(posedge clock) begin
		if (!reset) begin
			state <= h_idle;
		end else begin
			case (state)
				h_idle: begin
					if (load)
						state <= h_wr_cur;
					else if (read)
						state <= h_rd;
				end
				h_wr_cur:  if (grant) state <= h_wr_prev;
				h_wr_prev: if (grant) state <= h_idle;
				h_rd:      if (grant) state <= h_rd_wait;
				default:   state <= h_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == h_idle && (load || read)) begin
			addr_q <= host_addr;
			data_q <= host_data;
		end
		if (state == h_rd_wait)
			read_hold <= rdata;
	end

endmodule

/* rtl/patch_sweeper.sv */
`timescale 1ns/1ps

module patch_sweeper import drum_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        start,
	input  boundary_t   edges,
	output mem_req_t    mem_req,
	input  logic        grant,
	input  sample_t     rdata,
	output logic        launch,
	output neighbours_t nb,
	input  sample_t     u_next,
	input  logic        u_next_valid,
	output logic        rotate,
	output logic        busy,
	output logic        done
);

	localparam logic [2:0] last_slot = 3'd5;

	sweep_state_t state;
	node_addr_t   node;
	logic [2:0]   slot;	// prev, cur, right, left, up, down
	logic [1:0]   row;
	logic [1:0]   col;
	logic         outside;	// slot lies beyond the patch edge
	node_addr_t   slot_addr;
	level_t       slot_level;
	sample_t      slot_value;
	logic         store;

	assign row = node[3:2];
	assign col = node[1:0];

	always_comb begin
		outside    = 1'b0;
		slot_addr  = node;
		slot_level = level_cur;
		slot_value = rdata;
		case (slot)
			3'd0: slot_level = level_prev;
			3'd1: ;
			3'd2: begin
				outside    = (col == 2'(patch_dim - 1));
				slot_addr  = node + 4'd1;
				slot_value = outside ? edges.right : rdata;
			end
			3'd3: begin
				outside    = (col == 2'd0);
				slot_addr  = node - 4'd1;
				slot_value = outside ? edges.left : rdata;
			end
			3'd4: begin
				outside    = (row == 2'd0);
				slot_addr  = node - node_addr_t'(patch_dim);
				slot_value = outside ? edges.up : rdata;
			end
			default: begin
				outside    = (row == 2'(patch_dim - 1));
				slot_addr  = node + node_addr_t'(patch_dim);
				slot_value = outside ? edges.down : rdata;
			end
		endcase
	end

	always_comb begin
		mem_req = '0;
		if (state == s_read) begin
			mem_req.req   = !outside;	// edge slots skip the memory
			mem_req.level = slot_level;
			mem_req.addr  = slot_addr;
		end else if (state == s_write) begin
			mem_req.req   = 1'b1;
			mem_req.we    = 1'b1;
			mem_req.level = level_next;
			mem_req.addr  = node;
			mem_req.wdata = u_next;
		end
	end

	assign store  = (state == s_collect) || (state == s_read && outside);
	assign rotate = (state == s_rotate);
	assign done   = (state == s_done);
	assign busy   = (state != s_idle) && (state != s_done);

	always_ff @(posedge clock) begin
		if (!reset) begin
			state  <= s_idle;
			node   <= '0;
			slot   <= '0;
			launch <= 1'b0;
		end else begin
			launch <= 1'b0;
			case (state)
				s_idle, s_done: begin
					state <= s_idle;
					if (start) begin
						node  <= '0;
						slot  <= '0;
						state <= s_read;
					end
				end
				s_read: begin
					if (outside || grant)
						state <= outside ? s_read : s_collect;	// wait one cycle for rdata
					if (outside && slot == last_slot) begin
						launch <= 1'b1;
						state  <= s_compute;
					end else if (outside) begin
						slot <= slot + 3'd1;
					end
				end
				s_collect: begin
					if (slot == last_slot) begin
						launch <= 1'b1;
						state  <= s_compute;
					end else begin
						slot  <= slot + 3'd1;
						state <= s_read;
					end
				end
				s_compute: if (u_next_valid) state <= s_write;
				s_write: begin
					if (grant) begin
						slot <= '0;
						if (node == node_addr_t'(node_count - 1)) begin
							state <= s_rotate;
						end else begin
							node  <= node + 4'd1;
							state <= s_read;
						end
					end
				end
				s_rotate: state <= s_done;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (store) begin
			case (slot)
				3'd0:    nb.u_prev <= slot_value;
				3'd1:    nb.u_cur  <= slot_value;
				3'd2:    nb.right  <= slot_value;
				3'd3:    nb.left   <= slot_value;
				3'd4:    nb.up     <= slot_value;
				default: nb.down   <= slot_value;
			endcase
		end
	end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import drum_pkg::*; (
	input  mem_req_t host_req,
	input  mem_req_t sweep_req,
	output logic     host_grant,
	output logic     sweep_grant,
	output mem_req_t mem_req
);

	// host has fixed priority, the sweeper only gets idle cycles
	always_comb begin
		host_grant  = host_req.req;
		sweep_grant = sweep_req.req && !host_req.req;
		if (host_req.req)
			mem_req = host_req;
		else if (sweep_req.req)
			mem_req = sweep_req;
		else
			mem_req = '0;	// no access this cycle
	end

endmodule

/* rtl/state_memory.sv */
`timescale 1ns/1ps

module state_memory import drum_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  mem_req_t req,
	input  logic     rotate,
	output sample_t  rdata
);

	sample_t    mem [3][node_count];
	logic [1:0] cur_bank;	// physical bank holding level_cur
	logic [1:0] bank;

	// next sits one bank above cur, prev one below, modulo 3
	function automatic logic [1:0] bank_of(input logic [1:0] ptr, input level_t level);
		logic [1:0] off;
		logic [2:0] sum;
		case (level)
			level_cur:  off = 2'd0;
			level_next: off = 2'd1;
			default:    off = 2'd2;
		endcase
		sum = {1'b0, ptr} + {1'b0, off};
		bank_of = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
	endfunction

	assign bank = bank_of(cur_bank, req.level);

	always_ff @(posedge clock) begin
		if (!reset) begin
			cur_bank <= 2'd0;
		end else if (rotate) begin
			cur_bank <= (cur_bank == 2'd2) ? 2'd0 : cur_bank + 2'd1;	// next becomes cur
		end
	end

	always_ff @(posedge clock) begin
		if (req.req) begin
			if (req.we)
				mem[bank][req.addr] <= req.wdata;	// mapping before any rotate
			else
				rdata <= mem[bank][req.addr];
		end
	end

endmodule

/* rtl/node_update.sv */
`timescale 1ns/1ps

module node_update import drum_pkg::*; #(
	parameter int frac_bits = 17
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        launch,
	input  sample_t     rho,
	input  neighbours_t nb,
	output sample_t     u_next,
	output logic        u_next_valid
);

	localparam sample_t sample_max = 18'sh1ffff;
	localparam sample_t sample_min = -18'sh20000;

	logic signed [20:0] lap;	// neighbour sum minus 4 * u_cur
	logic signed [38:0] prod;
	logic signed [38:0] scaled;
	logic signed [40:0] total;	// full width before saturation
	sample_t            sat;

	always_comb begin
		lap = 21'(nb.right) + 21'(nb.left) + 21'(nb.up) + 21'(nb.down)
			- (21'(nb.u_cur) <<< 2);
		prod   = 39'(lap) * 39'(rho);
		scaled = prod >>> frac_bits;	// drop rho fraction
		total  = 41'(scaled) + (41'(nb.u_cur) <<< 1) - 41'(nb.u_prev);
		if (total > 41'(sample_max))
			sat = sample_max;
		else if (total < 41'(sample_min))
			sat = sample_min;
		else
			sat = total[17:0];
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			u_next_valid <= 1'b0;
		end else begin
			u_next_valid <= launch;	// one cycle latency
		end
	end

	always_ff @(posedge clock) begin
		if (launch)
			u_next <= sat;	// held until the next launch
	end

endmodule

/* rtl/drum_pkg.sv */
package drum_pkg;

	typedef logic signed [17:0] sample_t;	// displacement, fixed point

	localparam int patch_dim  = 4;	// nodes per side
	localparam int node_count = 16;	// nodes in the patch

	typedef logic [3:0] node_addr_t;	// row * 4 + column

	// logical time levels, mapped onto physical banks by the memory
	typedef enum logic [1:0] {
		level_prev = 2'd0,
		level_cur  = 2'd1,
		level_next = 2'd2
	} level_t;

	typedef struct packed {
		logic       req;	// request flag
		logic       we;	// write enable
		level_t     level;
		node_addr_t addr;
		sample_t    wdata;
	} mem_req_t;

	typedef struct packed {
		sample_t right;
		sample_t left;
		sample_t up;
		sample_t down;
	} boundary_t;

	typedef struct packed {
		sample_t u_prev;
		sample_t u_cur;
		sample_t right;
		sample_t left;
		sample_t up;
		sample_t down;
	} neighbours_t;

	typedef enum logic [2:0] {
		s_idle, s_read, s_collect, s_compute, s_write, s_rotate, s_done
	} sweep_state_t;

	typedef enum logic [2:0] {
		h_idle, h_wr_cur, h_wr_prev, h_rd, h_rd_wait
	} host_state_t;

endpackage
